/* bench/mvuChecker.sv */
/*
 * Scoreboard for mvuCore. Samples beats on enabled rising edges, keeps a
 * running signed dot-product per PE and queues the truncated group totals.
 * A result is popped on each edge that follows an enabled edge with vld_o high.
 */
`timescale 1ns/100ps

module mvuChecker #(
	parameter int unsigned PE = 4,
	parameter int unsigned SIMD = 8,
	parameter int unsigned ACT_W = 8,
	parameter int unsigned WEIGHT_W = 8,
	parameter int unsigned ACCU_W = 24
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic last_i,
	input  logic zero_i,
	input  logic [SIMD-1:0][ACT_W-1:0] act_i,
	input  logic [PE-1:0][SIMD-1:0][WEIGHT_W-1:0] weight_i,
	input  logic vld_o,
	input  logic [PE-1:0][ACCU_W-1:0] p_o,
	output int errCount_o,
	output int checkCount_o,
	output int pending_o
);

	typedef logic [PE-1:0][ACCU_W-1:0] result_t;

	result_t expQ [$];         // group totals waiting for vld_o
	longint groupSum [PE];     // open group, one per PE
	logic prevEn = 1'b0;       // last edge moved the pipeline
	logic prevRst = 1'b0;
	int errCount = 0;
	int checkCount = 0;
	int pending = 0;

	assign errCount_o = errCount;
	assign checkCount_o = checkCount;
	assign pending_o = pending;

	// signed activation times signed weight, summed over every lane
	function automatic longint dotRef(input logic [SIMD-1:0][ACT_W-1:0] act,
			input logic [SIMD-1:0][WEIGHT_W-1:0] wRow);
		longint sum;
		sum = 0;
		for (int k = 0; k < SIMD; k++) begin
			sum += longint'($signed(act[k])) * longint'($signed(wRow[k]));
		end
		return sum;
	endfunction

	always @(posedge clk) begin
		result_t want;
		result_t closed;
		// outputs here still hold what the previous edge produced
		if (prevRst && vld_o) begin
			$display("vld_o went high while rst was asserted");
			errCount++;
		end else if (prevEn && vld_o) begin
			if (expQ.size() == 0) begin
				$display("vld_o went high with no group result outstanding");
				errCount++;
			end else begin
				want = expQ.pop_front();
				checkCount++;
				for (int p = 0; p < PE; p++) begin
					if (p_o[p] !== want[p]) begin
						$display("error: p_o[%0d] expected %h got %h", p, want[p], p_o[p]);
						errCount++;
					end
				end
			end
		end
		if (rst) begin
			expQ.delete();  // in-flight groups are lost
			for (int p = 0; p < PE; p++) groupSum[p] = 0;
		end else if (en_i) begin
			for (int p = 0; p < PE; p++) begin
				if (!zero_i) groupSum[p] += dotRef(act_i, weight_i[p]);
			end
			if (last_i) begin
				for (int p = 0; p < PE; p++) begin
					closed[p] = groupSum[p][ACCU_W-1:0];  // output keeps low bits
					groupSum[p] = 0;
				end
				expQ.push_back(closed);
			end
		end
		prevEn = en_i && !rst;
		prevRst = rst;
		pending = expQ.size();
	end

endmodule

/* bench/mvuCore_asserts.sv */
/*
 * Control checks bound onto mvuCore. Covers reset, stall hold and
 * unknown vld_o. failCount lets the testbench fold these into its verdict.
 */
`timescale 1ns/100ps

module mvuCore_asserts #(
	parameter int unsigned PE = 4,
	parameter int unsigned ACCU_W = 24
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic vld_o,
	input logic [PE-1:0][ACCU_W-1:0] p_o
);

	int failCount = 0;  // read by the testbench at the end

	resetClearsVld: assert property (@(posedge clk) rst |=> !vld_o)
		else begin
			failCount++;
			$error("vld_o high in the cycle after rst");
		end

	// a stalled edge must not move the outputs
	stallHoldsOutputs: assert property (@(posedge clk) disable iff (rst)
		!en_i |=> $stable(p_o) && $stable(vld_o))
		else begin
			failCount++;
			$error("p_o or vld_o changed across a stalled cycle");
		end

	vldKnown: assert property (@(posedge clk) !rst |-> !$isunknown(vld_o))
		else begin
			failCount++;
			$error("vld_o unknown after reset");
		end

endmodule

/* bench/mvuTb.sv */
/*
 * Testbench for mvuCore with PE=4, SIMD=8, SEG_LEN=1 (three segments).
 * Stimulus comes from an LCG and is driven on the falling edge.
 * Results are scored by mvuChecker; control checks are bound in.
 */
`timescale 1ns/100ps

module mvuTb;

	localparam int unsigned PE = 4;
	localparam int unsigned SIMD = 8;
	localparam int unsigned ACT_W = 8;
	localparam int unsigned WEIGHT_W = 8;
	localparam int unsigned ACCU_W = 24;
	localparam int unsigned SEG_LEN = 1;
	localparam bit SIGNED_ACT = 1;
	localparam int RESET_CYCLES = 16;
	localparam int BEATS = 200;                 // beats per test
	localparam int NUM_TESTS = 5;
	localparam int DRAIN_LIMIT = 40;            // latency is 5, plenty of margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_TESTS * BEATS + 200;

	logic clk = 1'b0;
	logic rst;
	logic en_i;
	logic last_i;
	logic zero_i;
	logic [SIMD-1:0][ACT_W-1:0] act_i;
	logic [PE-1:0][SIMD-1:0][WEIGHT_W-1:0] weight_i;
	logic vld_o;
	logic [PE-1:0][ACCU_W-1:0] p_o;

	int chkErrors;
	int chkChecks;
	int pending;                    // group results not yet seen on vld_o
	int tbErrors = 0;
	int errorsBefore = 0;
	int checksBefore = 0;
	int cycleCount = 0;
	logic [31:0] rngState = 32'h538ee4f0;

	always #20 clk = ~clk;

	mvuCore #(
		.PE(PE), .SIMD(SIMD), .ACT_W(ACT_W), .WEIGHT_W(WEIGHT_W),
		.ACCU_W(ACCU_W), .SEG_LEN(SEG_LEN), .SIGNED_ACT(SIGNED_ACT)
	) dut (
		.clk(clk), .rst(rst), .en_i(en_i), .last_i(last_i), .zero_i(zero_i),
		.act_i(act_i), .weight_i(weight_i), .vld_o(vld_o), .p_o(p_o)
	);

	mvuChecker #(
		.PE(PE), .SIMD(SIMD), .ACT_W(ACT_W), .WEIGHT_W(WEIGHT_W), .ACCU_W(ACCU_W)
	) chk (
		.clk(clk), .rst(rst), .en_i(en_i), .last_i(last_i), .zero_i(zero_i),
		.act_i(act_i), .weight_i(weight_i), .vld_o(vld_o), .p_o(p_o),
		.errCount_o(chkErrors), .checkCount_o(chkChecks), .pending_o(pending)
	);

	bind mvuCore mvuCore_asserts #(.PE(PE), .ACCU_W(ACCU_W)) asserts (
		.clk(clk), .rst(rst), .en_i(en_i), .vld_o(vld_o), .p_o(p_o)
	);

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	task automatic randomizeData();
		logic [31:0] r;
		for (int s = 0; s < SIMD; s++) begin
			r = nextRand();
			act_i[s] = r[31 -: ACT_W];  // upper bits, the low ones cycle fast
			for (int p = 0; p < PE; p++) begin
				r = nextRand();
				weight_i[p][s] = r[31 -: WEIGHT_W];
			end
		end
	endtask

	// idle cycles carry junk on last/zero to show en_i gates them
	task automatic driveBeat(input bit lst, input bit zr, input bit stalls);
		logic [31:0] r;
		if (stalls) begin
			r = nextRand();
			while (r[31]) begin
				@(negedge clk);
				en_i = 1'b0;
				last_i = r[30];
				zero_i = r[29];
				randomizeData();
				r = nextRand();
			end
		end
		@(negedge clk);
		en_i = 1'b1;
		last_i = lst;
		zero_i = zr;
		randomizeData();
	endtask

	task automatic runGroups(input int beats, input int maxLen, input bit zeros,
			input bit stalls, input bit closeAtEnd);
		int left;
		logic [31:0] r;
		bit zr;
		left = 0;
		for (int b = 0; b < beats; b++) begin
			r = nextRand();
			if (left == 0) left = 1 + int'(r[31:29]) % maxLen;  // group of 1..maxLen
			zr = zeros && (r[23:16] < 8'd85);                    // about a third
			driveBeat(left == 1 || (closeAtEnd && b == beats - 1), zr, stalls);
			left--;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		en_i = 1'b1;
		last_i = 1'b0;
		zero_i = 1'b0;
		while (pending != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending != 0) begin
			$display("%0d group results never appeared on vld_o", pending);
			tbErrors++;
		end
	endtask

	task automatic finishTest(input int num, input string name);
		drain();
		$display("test %0d %s: %0d results checked, %0d errors", num, name,
			chkChecks - checksBefore, chkErrors + tbErrors - errorsBefore);
		checksBefore = chkChecks;
		errorsBefore = chkErrors + tbErrors;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles with tests unfinished", cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		int total;
		rst = 1'b1;
		en_i = 1'b0;
		last_i = 1'b0;
		zero_i = 1'b0;
		act_i = '0;
		weight_i = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		runGroups(BEATS, 1, 1'b0, 1'b0, 1'b1);
		finishTest(1, "single-beat groups");
		runGroups(BEATS, 8, 1'b0, 1'b0, 1'b1);
		finishTest(2, "multi-beat groups");
		runGroups(BEATS, 8, 1'b1, 1'b0, 1'b1);
		finishTest(3, "zero beats");
		runGroups(BEATS, 8, 1'b0, 1'b1, 1'b1);
		finishTest(4, "stalls");

		runGroups(BEATS / 4, 8, 1'b0, 1'b0, 1'b0);  // leave a group open
		@(negedge clk);
		rst = 1'b1;
		randomizeData();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		runGroups(BEATS - BEATS / 4, 8, 1'b0, 1'b0, 1'b1);
		finishTest(5, "reset mid-group");

		total = chkErrors + tbErrors + dut.asserts.failCount;
		$display("%0d tests, %0d results checked, %0d errors, %0d assertion failures",
			NUM_TESTS, chkChecks, chkErrors + tbErrors, dut.asserts.failCount);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
rtl/mvuPkg.sv
rtl/beatControl.sv
rtl/activationSkew.sv
rtl/weightSkew.sv
rtl/dotChain.sv
rtl/mvuCore.sv
bench/mvuCore_asserts.sv
bench/mvuChecker.sv
bench/mvuTb.sv

/* rtl/activationSkew.sv */
/*
 * Activation lane packing and skew. ACT_W must be 9 or less. Lanes are
 * sign- or zero-extended to 9 bits by SIGNED_ACT. Slice i is delayed by its
 * segment index minus one (never below zero) enabled cycles; the rest of the
 * skew sits in the slice's own input registers inside dotChain.
 */
`timescale 1ns/100ps

module activationSkew #(
	parameter int unsigned SIMD,
	parameter int unsigned ACT_W,
	parameter int unsigned SEG_LEN,
	parameter bit SIGNED_ACT,
	localparam int unsigned CHAIN_LEN = (SIMD + mvuPkg::LANES - 1) / mvuPkg::LANES
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic [SIMD-1:0][ACT_W-1:0] act_i,         // one beat of activations
	output mvuPkg::actSlice_t actLanes_o [CHAIN_LEN]  // skewed slices for the chain
);

	localparam int unsigned LANE_W = mvuPkg::ACT_LANE_W;

	// widened lanes before skew, grouped per slice
	wire [mvuPkg::LANES-1:0][LANE_W-1:0] lanes [CHAIN_LEN];

	for (genvar i = 0; i < CHAIN_LEN; i++) begin : genSlice
		localparam int unsigned SEG = i / SEG_LEN;           // segment of this slice
		localparam int unsigned DLY = SEG > 1 ? SEG - 1 : 0;  // external delay

		for (genvar j = 0; j < mvuPkg::LANES; j++) begin : genLane
			localparam int unsigned IDX = mvuPkg::LANES * i + j;

			if (IDX >= SIMD) begin : genPad
				assign lanes[i][j] = '0;  // short last slice, lane unused
			end else if (SIGNED_ACT) begin : genSigned
				assign lanes[i][j] = LANE_W'($signed(act_i[IDX]));
			end else begin : genUnsigned
				assign lanes[i][j] = LANE_W'(act_i[IDX]);  // ninth bit keeps it positive
			end
		end

		if (DLY > 0) begin : genDelay
			mvuPkg::actSlice_t dlyLine [DLY];

			always_ff @(posedge clk) begin
				if (rst) begin
					dlyLine <= '{default: '0};
				end else if (en_i) begin
					dlyLine[0] <= lanes[i];
					for (int k = 1; k < DLY; k++) begin
						dlyLine[k] <= dlyLine[k-1];
					end
				end
			end

			assign actLanes_o[i] = dlyLine[DLY-1];  // oldest entry matches slice depth
		end else begin : genDirect
			assign actLanes_o[i] = lanes[i];  // first two segments take the beat live
		end
	end

endmodule

/* rtl/beatControl.sv */
/*
 * Beat control for the dot-product chain. Carries last and zero down the
 * pipeline alongside the data. vld_o rises STAGES+2 enabled edges after the
 * edge that samples last_i and lasts one enabled cycle. en_i low freezes all.
 */
`timescale 1ns/100ps

module beatControl #(
	parameter int unsigned SIMD,
	parameter int unsigned SEG_LEN,
	localparam int unsigned CHAIN_LEN = (SIMD + mvuPkg::LANES - 1) / mvuPkg::LANES,
	localparam int unsigned STAGES = (CHAIN_LEN + SEG_LEN - 1) / SEG_LEN
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic last_i,
	input  logic zero_i,
	output logic [STAGES-1:0] zeroTap_o,  // zero flag per segment depth
	output mvuPkg::accuOp_t accuOp_o,     // mode for the final accumulator
	output logic vld_o
);

	// last travels from the top bit down to bit 0, which is vld
	logic [STAGES+1:0] lastPipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
			accuOp_o <= mvuPkg::ACCU_CONTINUE;
		end else if (en_i) begin
			lastPipe <= {last_i, lastPipe[STAGES+1:1]};  // shift toward vld
			// bit 1 is one ahead of vld, so the next beat into the accumulator restarts
			accuOp_o <= lastPipe[1] ? mvuPkg::ACCU_RESTART : mvuPkg::ACCU_CONTINUE;
		end
	end

	assign vld_o = lastPipe[0];  // group total is in the accumulator now

	// one zero register per segment boundary, tap k feeds slices of segment k
	if (STAGES > 1) begin : genZeroPipe
		logic [STAGES-2:0] zeroPipe;

		always_ff @(posedge clk) begin
			if (rst) begin
				zeroPipe <= '0;
			end else if (en_i) begin
				zeroPipe[0] <= zero_i;
				for (int k = 1; k < STAGES - 1; k++) begin
					zeroPipe[k] <= zeroPipe[k-1];  // follows the segment skew
				end
			end
		end

		assign zeroTap_o = {zeroPipe, zero_i};  // tap 0 is the live strobe
	end else begin : genZeroDirect
		assign zeroTap_o = zero_i;  // single segment, no skew needed
	end

endmodule

/* rtl/dotChain.sv */
/*
 * PE chains of three-lane multiply-accumulate slices. Per slice: one input
 * register (two outside the first segment), a product register forced to zero
 * by the segment's zero tap, and a cascade register where a segment ends.
 * The last slice accumulates; p_o keeps the low ACCU_W bits, so ACCU_W must
 * not exceed PROD_W and wider group sums wrap.
 */
`timescale 1ns/100ps

module dotChain #(
	parameter int unsigned PE,
	parameter int unsigned SIMD,
	parameter int unsigned ACCU_W,
	parameter int unsigned SEG_LEN,
	localparam int unsigned CHAIN_LEN = (SIMD + mvuPkg::LANES - 1) / mvuPkg::LANES,
	localparam int unsigned STAGES = (CHAIN_LEN + SEG_LEN - 1) / SEG_LEN
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  mvuPkg::actSlice_t actLanes_i [CHAIN_LEN],          // shared by all PEs
	input  mvuPkg::weightSlice_t weightLanes_i [PE][CHAIN_LEN],
	input  logic [STAGES-1:0] zeroTap_i,                        // zero flag per segment
	input  mvuPkg::accuOp_t accuOp_i,
	output logic [PE-1:0][ACCU_W-1:0] p_o
);

	localparam int unsigned AW = mvuPkg::ACT_LANE_W;
	localparam int unsigned WW = mvuPkg::WEIGHT_LANE_W;

	// output of each slice as seen by the next one down the chain
	mvuPkg::cascade_t casc [PE][CHAIN_LEN];

	for (genvar p = 0; p < PE; p++) begin : genPe
		for (genvar i = 0; i < CHAIN_LEN; i++) begin : genSlice
			localparam int unsigned SEG = i / SEG_LEN;
			localparam int unsigned IN_REGS = SEG > 0 ? 2 : 1;  // extra stage covers the skew
			localparam bit SEG_END = ((i + 1) % SEG_LEN == 0) || (i == CHAIN_LEN - 1);
			localparam bit FIRST = i == 0;
			localparam bit LAST = i == CHAIN_LEN - 1;

			mvuPkg::actSlice_t aReg [IN_REGS];
			mvuPkg::weightSlice_t bReg [IN_REGS];
			logic zeroReg;                // zero flag aligned with aReg/bReg
			mvuPkg::cascade_t prodSum;    // three-lane sum before the product register
			mvuPkg::cascade_t mReg;
			mvuPkg::cascade_t cascIn;
			mvuPkg::cascade_t sliceSum;
			mvuPkg::cascade_t sliceOut;

			// input stage, zero tap of this segment captured with the data
			always_ff @(posedge clk) begin
				if (rst) begin
					aReg <= '{default: '0};
					bReg <= '{default: '0};
					zeroReg <= 1'b0;
				end else if (en_i) begin
					aReg[0] <= actLanes_i[i];
					bReg[0] <= weightLanes_i[p][i];
					for (int k = 1; k < IN_REGS; k++) begin
						aReg[k] <= aReg[k-1];
						bReg[k] <= bReg[k-1];
					end
					zeroReg <= zeroTap_i[SEG];
				end
			end

			always_comb begin
				prodSum = '0;
				for (int k = 0; k < mvuPkg::LANES; k++) begin
					prodSum = prodSum
						+ mvuPkg::cascade_t'($signed(aReg[IN_REGS-1][AW*k +: AW]))
						* mvuPkg::cascade_t'($signed(bReg[IN_REGS-1][WW*k +: WW]));
				end
			end

			// product register, a zero beat contributes nothing
			always_ff @(posedge clk) begin
				if (rst) begin
					mReg <= '0;
				end else if (en_i) begin
					mReg <= zeroReg ? '0 : prodSum;
				end
			end

			if (FIRST) begin : genHead
				assign cascIn = '0;  // chain starts here
			end else begin : genLink
				assign cascIn = casc[p][i-1];
			end

			assign sliceSum = mReg + cascIn;

			if (LAST) begin : genAccu
				always_ff @(posedge clk) begin
					if (rst) begin
						sliceOut <= '0;
					end else if (en_i) begin
						sliceOut <= (accuOp_i == mvuPkg::ACCU_RESTART ? '0 : sliceOut) + sliceSum;
					end
				end

				assign p_o[p] = sliceOut[ACCU_W-1:0];  // truncated group total
			end else if (SEG_END) begin : genSegReg
				always_ff @(posedge clk) begin
					if (rst) begin
						sliceOut <= '0;
					end else if (en_i) begin
						sliceOut <= sliceSum;  // cut between segments
					end
				end
			end else begin : genPass
				assign sliceOut = sliceSum;  // same cycle into next slice
			end

			assign casc[p][i] = sliceOut;
		end
	end

endmodule

/* rtl/mvuCore.sv */
/*
 * Matrix-vector dot-product core, one activation vector shared by PE weight
 * rows. Results appear STAGES+2 enabled edges after a beat marked last, with
 * STAGES = ceil(ceil(SIMD/3)/SEG_LEN). No handshake; en_i stalls everything.
 * Limits: ACT_W <= 9, WEIGHT_W <= 8 (signed), ACCU_W <= 58, SEG_LEN >= 1.
 */
`timescale 1ns/100ps

module mvuCore #(
	parameter int unsigned PE = 4,
	parameter int unsigned SIMD = 8,
	parameter int unsigned ACT_W = 8,
	parameter int unsigned WEIGHT_W = 8,
	parameter int unsigned ACCU_W = 24,
	parameter int unsigned SEG_LEN = 1,
	parameter bit SIGNED_ACT = 1
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic last_i,                                // closes the group
	input  logic zero_i,                                // beat adds nothing
	input  logic [SIMD-1:0][ACT_W-1:0] act_i,
	input  logic [PE-1:0][SIMD-1:0][WEIGHT_W-1:0] weight_i,
	output logic vld_o,
	output logic [PE-1:0][ACCU_W-1:0] p_o
);

	localparam int unsigned CHAIN_LEN = (SIMD + mvuPkg::LANES - 1) / mvuPkg::LANES;
	localparam int unsigned STAGES = (CHAIN_LEN + SEG_LEN - 1) / SEG_LEN;

	mvuPkg::actSlice_t actLanes [CHAIN_LEN];
	mvuPkg::weightSlice_t weightLanes [PE][CHAIN_LEN];
	logic [STAGES-1:0] zeroTap;
	mvuPkg::accuOp_t accuOp;

	beatControl #(.SIMD(SIMD), .SEG_LEN(SEG_LEN)) ctrl (
		.clk(clk), .rst(rst), .en_i(en_i),
		.last_i(last_i), .zero_i(zero_i),
		.zeroTap_o(zeroTap), .accuOp_o(accuOp), .vld_o(vld_o)
	);

	activationSkew #(
		.SIMD(SIMD), .ACT_W(ACT_W), .SEG_LEN(SEG_LEN), .SIGNED_ACT(SIGNED_ACT)
	) actSkew (
		.clk(clk), .rst(rst), .en_i(en_i),
		.act_i(act_i), .actLanes_o(actLanes)
	);

	weightSkew #(
		.PE(PE), .SIMD(SIMD), .WEIGHT_W(WEIGHT_W), .SEG_LEN(SEG_LEN)
	) wgtSkew (
		.clk(clk), .rst(rst), .en_i(en_i),
		.weight_i(weight_i), .weightLanes_o(weightLanes)
	);

	dotChain #(
		.PE(PE), .SIMD(SIMD), .ACCU_W(ACCU_W), .SEG_LEN(SEG_LEN)
	) chain (
		.clk(clk), .rst(rst), .en_i(en_i),
		.actLanes_i(actLanes), .weightLanes_i(weightLanes),
		.zeroTap_i(zeroTap), .accuOp_i(accuOp),
		.p_o(p_o)
	);

endmodule

/* rtl/mvuPkg.sv */
/*
 * Shared lane geometry and types for the MVU dot-product core.
 * Slices are three lanes wide: 9-bit activations against 8-bit weights,
 * summed in a 58-bit cascade. Activations wider than 9 bits and weights
 * wider than 8 bits are not supported.
 */
package mvuPkg;

	localparam int unsigned LANES = 3;          // products per slice
	localparam int unsigned ACT_LANE_W = 9;     // activation lane, room for unsigned 8-bit
	localparam int unsigned WEIGHT_LANE_W = 8;  // weight lane, always signed
	localparam int unsigned PROD_W = 58;        // cascade and accumulator width

	// three activation lanes, lane 0 in the low bits
	typedef logic [LANES*ACT_LANE_W-1:0] actSlice_t;

	// three weight lanes, same ordering as actSlice_t
	typedef logic [LANES*WEIGHT_LANE_W-1:0] weightSlice_t;

	// partial sum handed from one slice to the next
	typedef logic signed [PROD_W-1:0] cascade_t;

	// accumulator mode of the last slice in a chain
	typedef enum logic {
		ACCU_CONTINUE,  // add new beat to held total
		ACCU_RESTART    // previous beat closed a group, start over
	} accuOp_t;

endpackage

/* rtl/weightSkew.sv */
/*
 * Weight lane packing and skew, one row of SIMD weights per PE. Weights are
 * signed and WEIGHT_W must be 8 or less; they are sign-extended to 8 bits.
 * Slice delays follow the same rule as the activation skew so that both
 * operands of a slice belong to the same beat.
 */
`timescale 1ns/100ps

module weightSkew #(
	parameter int unsigned PE,
	parameter int unsigned SIMD,
	parameter int unsigned WEIGHT_W,
	parameter int unsigned SEG_LEN,
	localparam int unsigned CHAIN_LEN = (SIMD + mvuPkg::LANES - 1) / mvuPkg::LANES
) (
	input  logic clk,
	input  logic rst,
	input  logic en_i,
	input  logic [PE-1:0][SIMD-1:0][WEIGHT_W-1:0] weight_i,   // weight rows per PE
	output mvuPkg::weightSlice_t weightLanes_o [PE][CHAIN_LEN] // skewed slices per PE
);

	localparam int unsigned LANE_W = mvuPkg::WEIGHT_LANE_W;

	// widened lanes before skew
	wire [mvuPkg::LANES-1:0][LANE_W-1:0] lanes [PE][CHAIN_LEN];

	for (genvar p = 0; p < PE; p++) begin : genPe
		for (genvar i = 0; i < CHAIN_LEN; i++) begin : genSlice
			localparam int unsigned SEG = i / SEG_LEN;
			localparam int unsigned DLY = SEG > 1 ? SEG - 1 : 0;  // same skew as activations

			for (genvar j = 0; j < mvuPkg::LANES; j++) begin : genLane
				localparam int unsigned IDX = mvuPkg::LANES * i + j;

				if (IDX < SIMD) begin : genUsed
					assign lanes[p][i][j] = LANE_W'($signed(weight_i[p][IDX]));
				end else begin : genPad
					assign lanes[p][i][j] = '0;  // zero weight kills the padded product
				end
			end

			if (DLY > 0) begin : genDelay
				mvuPkg::weightSlice_t dlyLine [DLY];

				always_ff @(posedge clk) begin
					if (rst) begin
						dlyLine <= '{default: '0};
					end else if (en_i) begin
						dlyLine[0] <= lanes[p][i];
						for (int k = 1; k < DLY; k++) begin
							dlyLine[k] <= dlyLine[k-1];
						end
					end
				end

				assign weightLanes_o[p][i] = dlyLine[DLY-1];
			end else begin : genDirect
				assign weightLanes_o[p][i] = lanes[p][i];
			end
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module mvuTb -Mdir obj_dir -o mvuSim \
	-f project.f \
	&& ./obj_dir/mvuSim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
